// ==== source/icache_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache sizes: address, line,
// index, ways and request ID widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

`define ICACHE_ADDR_W      32
`define ICACHE_LINE_W      64
`define ICACHE_OFFSET_W    3
`define ICACHE_LINE_COUNT  16
`define ICACHE_INDEX_W     4
`define ICACHE_WAYS        2
`define ICACHE_WAY_W       1
`define ICACHE_ID_W        4
// Address bits left above index and offset
`define ICACHE_TAG_W       25

`endif

// ==== source/icache_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache types: fetch address
// union, tag entry and lookup result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "icache_settings.svh"

package icache_pkg;

    // One fetch address, seen raw or split into its fields
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;
        struct packed {
            logic [`ICACHE_TAG_W-1:0]    tag;
            logic [`ICACHE_INDEX_W-1:0]  index;
            logic [`ICACHE_OFFSET_W-1:0] offset;
        } f;
    } icache_addr_u;

    // Word kept in each tag bank
    typedef struct packed {
        logic                     valid;
        logic                     error;
        logic [`ICACHE_TAG_W-1:0] tag;
    } icache_tag_entry_t;

    typedef struct packed {
        icache_addr_u              addr;
        logic [`ICACHE_ID_W-1:0]   id;
        logic [`ICACHE_WAY_W-1:0]  way;
        logic                      hit;
        logic                      error;
        logic [`ICACHE_LINE_W-1:0] data;
    } icache_result_t;

endpackage

// ==== source/icache_write_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Refill write channel from the miss
// handler into the lookup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "icache_settings.svh"

interface icache_write_if;

    logic [`ICACHE_INDEX_W-1:0] index;
    logic [`ICACHE_WAY_W-1:0]   way;
    logic [`ICACHE_LINE_W-1:0]  data;
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic                       error;
    logic                       valid;
    logic                       ready;

    modport source (output index, way, data, tag, error, valid, input ready);
    modport sink (input index, way, data, tag, error, valid, output ready);

endinterface

// ==== source/icache_sram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port synchronous RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_sram #(
    parameter int unsigned  DATA_W = `ICACHE_LINE_W,
    parameter int unsigned  WORDS  = `ICACHE_LINE_COUNT,
    localparam int unsigned ADDR_W = $clog2(WORDS)
) (
    input  logic              clk_i,
    input  logic              req_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o
);

    logic [DATA_W-1:0] mem_q [WORDS];

    // Read data held until the next read
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

// ==== source/icache_lookup.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache lookup: tag sweep, write/lookup mux,
// tag compare stage and data read stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_valid_i,
    output logic                    flush_ready_o,
    input  icache_addr_u            in_addr_i,
    input  logic [`ICACHE_ID_W-1:0] in_id_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    output icache_result_t          out_result_o,
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    icache_write_if.sink            write_i
);

    localparam int unsigned DATA_ADDR_W = `ICACHE_WAY_W + `ICACHE_INDEX_W;
    localparam logic [`ICACHE_INDEX_W:0] SWEEP_END = (`ICACHE_INDEX_W + 1)'(`ICACHE_LINE_COUNT);

    logic [`ICACHE_INDEX_W:0]   sweep_q;
    logic                       sweeping;
    logic [`ICACHE_WAYS-1:0]    tag_req;
    logic                       tag_we;
    logic [`ICACHE_INDEX_W-1:0] tag_addr;
    icache_tag_entry_t          tag_wdata;
    icache_tag_entry_t          tag_rdata [`ICACHE_WAYS];
    icache_addr_u               write_addr;
    logic                       write_fire;
    logic                       in_fire;
    logic                       out_fire;
    logic                       t_free;
    logic                       t_advance;
    logic                       lookup_ok;
    logic                       t_valid_q;
    logic                       t_write_q;
    icache_addr_u               t_addr_q;
    logic [`ICACHE_ID_W-1:0]    t_id_q;
    logic [`ICACHE_WAY_W-1:0]   t_way_q;
    logic [`ICACHE_LINE_W-1:0]  t_data_q;
    logic [`ICACHE_WAYS-1:0]    way_hit;
    logic [`ICACHE_WAYS-1:0]    way_err;
    logic [`ICACHE_WAY_W-1:0]   hit_way;
    logic                       d_enter;
    logic [DATA_ADDR_W-1:0]     data_addr;
    logic [`ICACHE_LINE_W-1:0]  data_rdata;
    logic                       d_valid_q;
    logic                       d_loaded_q;
    icache_addr_u               d_addr_q;
    logic [`ICACHE_ID_W-1:0]    d_id_q;
    logic [`ICACHE_WAY_W-1:0]   d_way_q;
    logic                       d_hit_q;
    logic                       d_error_q;
    logic [`ICACHE_LINE_W-1:0]  d_data_q;

    // Tag clear sweep after reset and after each flush
    assign sweeping      = (sweep_q != SWEEP_END);
    assign flush_ready_o = flush_valid_i & ~sweeping;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sweep_q <= '0;
        end else if (flush_ready_o) begin
            sweep_q <= '0;
        end else if (sweeping) begin
            sweep_q <= sweep_q + 1'b1;
        end
    end

    // Writes pass the data stage even while a result waits there.
    // At most one lookup waits in the data stage, so a refill always
    // finds the tag stage free
    assign out_fire  = out_valid_o & out_ready_i;
    assign t_advance = t_valid_q & (t_write_q | ~d_valid_q | out_fire);
    assign t_free    = ~t_valid_q | t_advance;
    assign lookup_ok = (~t_valid_q | t_write_q) & (~d_valid_q | out_fire);

    // Port mux, sweep first, then refill writes, then lookups
    always_comb begin
        write_i.ready = 1'b0;
        in_ready_o    = 1'b0;
        tag_req       = '0;
        tag_we        = 1'b0;
        tag_addr      = in_addr_i.f.index;
        tag_wdata     = '0;
        if (sweeping) begin
            tag_req  = '1;
            tag_we   = 1'b1;
            tag_addr = sweep_q[`ICACHE_INDEX_W-1:0];
        end else if (write_i.valid) begin
            write_i.ready          = t_free;
            tag_req[write_i.way]   = t_free;
            tag_we                 = 1'b1;
            tag_addr               = write_i.index;
            tag_wdata.valid        = 1'b1;
            tag_wdata.error        = write_i.error;
            tag_wdata.tag          = write_i.tag;
        end else begin
            in_ready_o = lookup_ok;
            tag_req    = {`ICACHE_WAYS{in_valid_i & lookup_ok}};
        end
    end

    assign write_fire     = write_i.valid & write_i.ready;
    assign in_fire        = in_valid_i & in_ready_o;
    assign write_addr.raw = {write_i.tag, write_i.index, {`ICACHE_OFFSET_W{1'b0}}};

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_tag_bank
        icache_sram #(
            .DATA_W ($bits(icache_tag_entry_t)),
            .WORDS  (`ICACHE_LINE_COUNT)
        ) tag_bank_i (
            .clk_i   (clk_i),
            .req_i   (tag_req[w]),
            .we_i    (tag_we),
            .addr_i  (tag_addr),
            .wdata_i (tag_wdata),
            .rdata_o (tag_rdata[w])
        );
    end

    // Tag stage
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            t_valid_q <= 1'b0;
            t_write_q <= 1'b0;
        end else if (t_free) begin
            t_valid_q <= write_fire | in_fire;
            t_write_q <= write_fire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_fire) begin
            t_addr_q <= write_addr;
            t_way_q  <= write_i.way;
            t_data_q <= write_i.data;
        end else if (in_fire) begin
            t_addr_q <= in_addr_i;
            t_id_q   <= in_id_i;
        end
    end

    // Compare both ways, lowest way wins
    always_comb begin
        way_hit = '0;
        way_err = '0;
        hit_way = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            way_hit[w] = tag_rdata[w].valid && (tag_rdata[w].tag == t_addr_q.f.tag);
            way_err[w] = way_hit[w] && tag_rdata[w].error;
            if (way_hit[w]) begin
                hit_way = w[`ICACHE_WAY_W-1:0];
            end
        end
    end

    // Data stage, refills write the bank and leave no result
    assign d_enter   = t_advance & ~t_write_q;
    assign data_addr = {(t_write_q ? t_way_q : hit_way), t_addr_q.f.index};

    icache_sram #(
        .DATA_W (`ICACHE_LINE_W),
        .WORDS  (`ICACHE_LINE_COUNT * `ICACHE_WAYS)
    ) data_bank_i (
        .clk_i   (clk_i),
        .req_i   (t_advance),
        .we_i    (t_write_q),
        .addr_i  (data_addr),
        .wdata_i (t_data_q),
        .rdata_o (data_rdata)
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            d_valid_q  <= 1'b0;
            d_loaded_q <= 1'b0;
        end else if (d_enter) begin
            d_valid_q  <= 1'b1;
            d_loaded_q <= 1'b0;
        end else begin
            if (out_fire) begin
                d_valid_q <= 1'b0;
            end
            if (d_valid_q) begin
                d_loaded_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (d_enter) begin
            d_addr_q  <= t_addr_q;
            d_id_q    <= t_id_q;
            d_way_q   <= hit_way;
            d_hit_q   <= |way_hit;
            d_error_q <= |way_err;
        end
        // Line captured once, then held through a stall
        if (d_valid_q && !d_loaded_q) begin
            d_data_q <= data_rdata;
        end
    end

    assign out_valid_o = d_valid_q & d_loaded_q;

    always_comb begin
        out_result_o.addr  = d_addr_q;
        out_result_o.id    = d_id_q;
        out_result_o.way   = d_way_q;
        out_result_o.hit   = d_hit_q;
        out_result_o.error = d_error_q;
        out_result_o.data  = d_data_q;
    end

endmodule

// ==== source/icache_miss_handler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Miss handler: hit forwarding, line refill,
// round-robin victim and fetch response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_miss_handler
    import icache_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  icache_result_t            res_i,
    input  logic                      res_valid_i,
    output logic                      res_ready_o,
    output logic [`ICACHE_ADDR_W-1:0] mem_req_addr_o,
    output logic                      mem_req_valid_o,
    input  logic                      mem_req_ready_i,
    input  logic [`ICACHE_LINE_W-1:0] mem_rsp_data_i,
    input  logic                      mem_rsp_error_i,
    input  logic                      mem_rsp_valid_i,
    icache_write_if.source            write_o,
    output logic [`ICACHE_LINE_W-1:0] rsp_data_o,
    output logic [`ICACHE_ID_W-1:0]   rsp_id_o,
    output logic                      rsp_hit_o,
    output logic                      rsp_error_o,
    output logic                      rsp_valid_o
);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_REQ   = 3'd1;
    localparam logic [2:0] ST_WAIT  = 3'd2;
    localparam logic [2:0] ST_WRITE = 3'd3;
    localparam logic [2:0] ST_RESP  = 3'd4;

    logic [2:0]                state_q;
    logic [2:0]                state_d;
    logic                      res_fire;
    logic                      refill_done;
    logic                      hit_rsp_q;
    logic [`ICACHE_WAY_W-1:0]  victim_q;
    icache_addr_u              miss_addr_q;
    icache_addr_u              line_addr;
    logic [`ICACHE_LINE_W-1:0] line_q;
    logic                      line_err_q;

    // Results are taken only while no miss is open
    assign res_ready_o = (state_q == ST_IDLE);
    assign res_fire    = res_valid_i & res_ready_o;
    assign refill_done = (state_q == ST_WRITE) & write_o.ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (res_fire && !res_i.hit) state_d = ST_REQ;
            ST_REQ:   if (mem_req_ready_i) state_d = ST_WAIT;
            ST_WAIT:  if (mem_rsp_valid_i) state_d = ST_WRITE;
            ST_WRITE: if (write_o.ready) state_d = ST_RESP;
            ST_RESP:  state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= ST_IDLE;
            hit_rsp_q <= 1'b0;
            victim_q  <= '0;
        end else begin
            state_q   <= state_d;
            hit_rsp_q <= res_fire & res_i.hit;
            if (refill_done) begin
                victim_q <= victim_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (res_fire) begin
            miss_addr_q <= res_i.addr;
            rsp_id_o    <= res_i.id;
            rsp_hit_o   <= res_i.hit;
            rsp_error_o <= res_i.error;
            rsp_data_o  <= res_i.data;
        end else if (refill_done) begin
            rsp_error_o <= line_err_q;
            rsp_data_o  <= line_q;
        end
        if ((state_q == ST_WAIT) && mem_rsp_valid_i) begin
            line_q     <= mem_rsp_data_i;
            line_err_q <= mem_rsp_error_i;
        end
    end

    // Memory fetches whole lines
    always_comb begin
        line_addr          = miss_addr_q;
        line_addr.f.offset = '0;
    end

    assign mem_req_addr_o  = line_addr.raw;
    assign mem_req_valid_o = (state_q == ST_REQ);

    // Error kept in the tag entry so later hits report it too
    assign write_o.valid = (state_q == ST_WRITE);
    assign write_o.index = miss_addr_q.f.index;
    assign write_o.tag   = miss_addr_q.f.tag;
    assign write_o.way   = victim_q;
    assign write_o.data  = line_q;
    assign write_o.error = line_err_q;

    assign rsp_valid_o = hit_rsp_q | (state_q == ST_RESP);

endmodule

// ==== source/icache_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache top: lookup pipeline
// and miss handler
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      flush_valid_i,
    output logic                      flush_ready_o,

    input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
    input  logic [`ICACHE_ID_W-1:0]   fetch_id_i,
    input  logic                      fetch_valid_i,
    output logic                      fetch_ready_o,

    output logic [`ICACHE_LINE_W-1:0] fetch_rsp_data_o,
    output logic [`ICACHE_ID_W-1:0]   fetch_rsp_id_o,
    output logic                      fetch_rsp_hit_o,
    output logic                      fetch_rsp_error_o,
    output logic                      fetch_rsp_valid_o,

    output logic [`ICACHE_ADDR_W-1:0] mem_req_addr_o,
    output logic                      mem_req_valid_o,
    input  logic                      mem_req_ready_i,
    input  logic [`ICACHE_LINE_W-1:0] mem_rsp_data_i,
    input  logic                      mem_rsp_error_i,
    input  logic                      mem_rsp_valid_i
);

    icache_result_t result;
    logic           result_valid;
    logic           result_ready;

    // Refill path from the handler back into the lookup
    icache_write_if write_if ();

    icache_lookup icache_lookup_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_valid_i (flush_valid_i),
        .flush_ready_o (flush_ready_o),
        .in_addr_i     (fetch_addr_i),
        .in_id_i       (fetch_id_i),
        .in_valid_i    (fetch_valid_i),
        .in_ready_o    (fetch_ready_o),
        .out_result_o  (result),
        .out_valid_o   (result_valid),
        .out_ready_i   (result_ready),
        .write_i       (write_if.sink)
    );

    icache_miss_handler icache_miss_handler_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .res_i           (result),
        .res_valid_i     (result_valid),
        .res_ready_o     (result_ready),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_rsp_error_i (mem_rsp_error_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .write_o         (write_if.source),
        .rsp_data_o      (fetch_rsp_data_o),
        .rsp_id_o        (fetch_rsp_id_o),
        .rsp_hit_o       (fetch_rsp_hit_o),
        .rsp_error_o     (fetch_rsp_error_o),
        .rsp_valid_o     (fetch_rsp_valid_o)
    );

endmodule

// ==== verif/icache_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake and reset assertions for
// the instruction cache, bound to the top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_assertions (
    input logic                      clk_i,
    input logic                      rst_ni,
    input logic                      mem_req_valid_i,
    input logic                      mem_req_ready_i,
    input logic [`ICACHE_ADDR_W-1:0] mem_req_addr_i,
    input logic                      rsp_valid_i,
    input logic                      flush_valid_i,
    input logic                      flush_ready_i,
    input logic                      fetch_ready_i
);

    int unsigned              failure_count = 0;
    logic [`ICACHE_INDEX_W:0] sweep_left_q;

    // Cycles of tag clearing still due after reset or a flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sweep_left_q <= (`ICACHE_INDEX_W + 1)'(`ICACHE_LINE_COUNT);
        end else if (flush_valid_i && flush_ready_i) begin
            sweep_left_q <= (`ICACHE_INDEX_W + 1)'(`ICACHE_LINE_COUNT);
        end else if (sweep_left_q != 0) begin
            sweep_left_q <= sweep_left_q - 1'b1;
        end
    end

    // Memory request stays up with the same line until taken
    mem_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_addr_i))
    else begin
        $error("memory request dropped or changed before ready");
        failure_count++;
    end

    rsp_quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !rsp_valid_i)
    else begin
        $error("fetch response valid while in reset");
        failure_count++;
    end

    // Tags are being cleared, no lookup may enter
    no_fetch_in_sweep: assert property (@(posedge clk_i) disable iff (!rst_ni)
        sweep_left_q != 0 |-> !fetch_ready_i)
    else begin
        $error("fetch ready raised during the tag sweep");
        failure_count++;
    end

endmodule

bind icache_top icache_assertions assertions_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_i  (mem_req_addr_o),
    .rsp_valid_i     (fetch_rsp_valid_o),
    .flush_valid_i   (flush_valid_i),
    .flush_ready_i   (flush_ready_o),
    .fetch_ready_i   (fetch_ready_o)
);

// ==== verif/icache_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache testbench: stimulus,
// memory model, hit model and checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic                      clk_i = 1'b0;
    logic                      rst_ni;
    logic                      flush_valid_i;
    logic                      flush_ready_o;
    logic [`ICACHE_ADDR_W-1:0] fetch_addr_i;
    logic [`ICACHE_ID_W-1:0]   fetch_id_i;
    logic                      fetch_valid_i;
    logic                      fetch_ready_o;
    logic [`ICACHE_LINE_W-1:0] fetch_rsp_data_o;
    logic [`ICACHE_ID_W-1:0]   fetch_rsp_id_o;
    logic                      fetch_rsp_hit_o;
    logic                      fetch_rsp_error_o;
    logic                      fetch_rsp_valid_o;
    logic [`ICACHE_ADDR_W-1:0] mem_req_addr_o;
    logic                      mem_req_valid_o;
    logic                      mem_req_ready_i;
    logic [`ICACHE_LINE_W-1:0] mem_rsp_data_i;
    logic                      mem_rsp_error_i;
    logic                      mem_rsp_valid_i;

    logic [15:0]               lfsr_q = 16'd36774;
    logic [`ICACHE_ID_W-1:0]   next_id = '0;
    int unsigned               refill_count = 0;
    int unsigned               rsp_count = 0;
    logic                      mem_busy = 1'b0;
    logic                      mem_ready_next = 1'b0;
    logic [2:0]                mem_delay;
    logic [`ICACHE_ADDR_W-1:0] mem_line;

    // Outstanding requests, oldest first
    logic [`ICACHE_ID_W-1:0]   exp_id_q [$];
    logic [`ICACHE_ADDR_W-1:0] exp_addr_q [$];
    logic                      exp_hit_q [$];
    logic                      hit_checked_q [$];

    // Residency per index and way
    logic [`ICACHE_TAG_W-1:0]  model_tag [`ICACHE_LINE_COUNT][`ICACHE_WAYS];
    logic                      model_valid [`ICACHE_LINE_COUNT][`ICACHE_WAYS];

    icache_top icache_top_i (.*);

    always #4 clk_i = ~clk_i;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    function automatic logic next_random_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], next_random_bit()};
        end
        return val;
    endfunction

    // Expected line contents, a fixed mix of the line address
    function automatic logic [`ICACHE_LINE_W-1:0] ref_line(input logic [31:0] addr);
        logic [31:0] line;
        line = {addr[31:3], 3'b000};
        return {line ^ 32'hC3A5_9617, {line[15:0], line[31:16]} + 32'h0F1E_2D3C};
    endfunction

    // Marked range returns a bus error
    function automatic logic ref_error(input logic [31:0] addr);
        return (addr >= 32'h0000_2000) && (addr < 32'h0000_2800);
    endfunction

    // Pool of lines, three share index 2
    function automatic logic [`ICACHE_ADDR_W-1:0] pool_line(input int k);
        case (k)
            0: return {25'h1, 4'd2, 3'd0};
            1: return {25'h2, 4'd2, 3'd0};
            2: return {25'h3, 4'd2, 3'd0};
            3: return {25'h1, 4'd5, 3'd0};
            4: return {25'h40, 4'd5, 3'd0};
            5: return {25'h5, 4'd9, 3'd0};
            6: return {25'h41, 4'd9, 3'd0};
            default: return {25'h7, 4'd12, 3'd0};
        endcase
    endfunction

    // Hit prediction, a miss fills the round-robin victim way
    function automatic logic predict_hit(input logic [`ICACHE_ADDR_W-1:0] addr);
        icache_addr_u a;
        int           victim;
        a.raw = addr;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (model_valid[a.f.index][w] && model_tag[a.f.index][w] == a.f.tag) begin
                return 1'b1;
            end
        end
        victim = refill_count % `ICACHE_WAYS;
        model_valid[a.f.index][victim] = 1'b1;
        model_tag[a.f.index][victim]   = a.f.tag;
        return 1'b0;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < `ICACHE_LINE_COUNT; i++) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                model_valid[i][w] = 1'b0;
            end
        end
    endtask

    task automatic check_line(input string what, input logic [`ICACHE_LINE_W-1:0] got, exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR @%0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_id(input string what, input logic [`ICACHE_ID_W-1:0] got, exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR @%0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR @%0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    // Memory model, one line request at a time
    always @(negedge clk_i) begin
        if (rst_ni && mem_req_valid_o && mem_req_ready_i && !mem_busy) begin
            mem_busy     = 1'b1;
            mem_line     = mem_req_addr_o;
            mem_delay    = 3'(random_bits(3));
            refill_count = refill_count + 1;
        end
        mem_ready_next = random_bits(1) != 0;
    end

    always @(posedge clk_i) begin
        #1;
        mem_req_ready_i = mem_ready_next;
        mem_rsp_valid_i = 1'b0;
        if (mem_busy) begin
            if (mem_delay == 0) begin
                mem_rsp_valid_i = 1'b1;
                mem_rsp_data_i  = ref_line(mem_line);
                mem_rsp_error_i = ref_error(mem_line);
                mem_busy        = 1'b0;
            end else begin
                mem_delay = mem_delay - 1'b1;
            end
        end
    end

    // Every response against the oldest request
    always @(negedge clk_i) begin : compare_rsp
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic                      hit;
        logic                      hit_checked;
        if (icache_top_i.assertions_i.failure_count != 0) begin
            fail_run("A bound assertion failed");
        end
        if (rst_ni && fetch_rsp_valid_o) begin
            if (exp_id_q.size() == 0) begin
                fail_run("Fetch response arrived with no request outstanding");
            end else begin
                addr        = exp_addr_q.pop_front();
                hit         = exp_hit_q.pop_front();
                hit_checked = hit_checked_q.pop_front();
                check_id("response ID", fetch_rsp_id_o, exp_id_q.pop_front());
                check_line("line data", fetch_rsp_data_o, ref_line(addr));
                check_flag("error flag", fetch_rsp_error_o, ref_error(addr));
                if (hit_checked) begin
                    check_flag("hit flag", fetch_rsp_hit_o, hit);
                end
                rsp_count = rsp_count + 1;
            end
        end
    end

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send_fetch(input logic [`ICACHE_ADDR_W-1:0] addr, input logic exp_hit,
                              input logic hit_checked);
        int cycles;
        fetch_addr_i  = addr;
        fetch_id_i    = next_id;
        fetch_valid_i = 1'b1;
        cycles        = 0;
        @(negedge clk_i);
        while (!fetch_ready_o) begin
            if (cycles == TIMEOUT) begin
                fail_run("Timed out waiting for fetch ready");
            end
            cycles++;
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        fetch_valid_i = 1'b0;
        exp_id_q.push_back(next_id);
        exp_addr_q.push_back(addr);
        exp_hit_q.push_back(exp_hit);
        hit_checked_q.push_back(hit_checked);
        next_id = next_id + 1'b1;
    endtask

    // One request alone in the cache, hit predicted
    task automatic run_single(input logic [`ICACHE_ADDR_W-1:0] addr);
        logic        exp_hit;
        int unsigned refills_before;
        int unsigned rsp_before;
        int          cycles;
        exp_hit        = predict_hit(addr);
        refills_before = refill_count;
        rsp_before     = rsp_count;
        cycles         = 0;
        send_fetch(addr, exp_hit, 1'b1);
        while (rsp_count == rsp_before) begin
            if (cycles == TIMEOUT) begin
                fail_run("Timed out waiting for the fetch response");
            end
            cycles++;
            @(posedge clk_i);
            #1;
        end
        if (refill_count != refills_before + (exp_hit ? 0 : 1)) begin
            fail_run($sformatf("ERR @%0t: %0d memory requests for %h, expected %0d", $time,
                               refill_count - refills_before, addr, exp_hit ? 0 : 1));
        end
    endtask

    task automatic check_sweep();
        int low_cycles;
        low_cycles = 0;
        @(negedge clk_i);
        while (!fetch_ready_o) begin
            if (low_cycles == TIMEOUT) begin
                fail_run("Fetch ready never rose after the tag sweep");
            end
            low_cycles++;
            @(negedge clk_i);
        end
        if (low_cycles != `ICACHE_LINE_COUNT) begin
            fail_run($sformatf("ERR @%0t: fetch ready low for %0d cycles, expected %0d",
                               $time, low_cycles, `ICACHE_LINE_COUNT));
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic flush_cache();
        int cycles;
        flush_valid_i = 1'b1;
        cycles        = 0;
        @(negedge clk_i);
        while (!flush_ready_o) begin
            if (cycles == TIMEOUT) begin
                fail_run("Timed out waiting for flush ready");
            end
            cycles++;
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        flush_valid_i = 1'b0;
        clear_model();
        check_sweep();
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (exp_id_q.size() != 0) begin
            if (cycles == TIMEOUT) begin
                fail_run("Timed out waiting for outstanding responses");
            end
            cycles++;
            @(posedge clk_i);
            #1;
        end
    endtask

    initial begin
        int k;
        rst_ni          = 1'b0;
        flush_valid_i   = 1'b0;
        fetch_addr_i    = '0;
        fetch_id_i      = '0;
        fetch_valid_i   = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_data_i  = '0;
        mem_rsp_error_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        clear_model();
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_sweep();

        // First touch misses, second touch hits
        for (int pass = 0; pass < 2; pass++) begin
            for (k = 0; k < 8; k++) begin
                if (k != 2) begin
                    run_single(pool_line(k) | random_bits(3));
                end
            end
        end

        // Third line on index 2 pushes out the victim way
        run_single(pool_line(2) | random_bits(3));
        run_single(pool_line(0) | random_bits(3));
        run_single(pool_line(1) | random_bits(3));
        run_single(pool_line(2) | random_bits(3));

        // Back-to-back stream, hit flag left open
        for (int n = 0; n < 48; n++) begin
            k = random_bits(3);
            send_fetch(pool_line(k) | random_bits(3), 1'b0, 1'b0);
        end
        drain();

        flush_cache();
        for (int pass = 0; pass < 2; pass++) begin
            for (k = 0; k < 8; k++) begin
                run_single(pool_line(k) | random_bits(3));
            end
        end
        drain();

        if (icache_top_i.assertions_i.failure_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_run($sformatf("Bound assertions failed %0d times",
                               icache_top_i.assertions_i.failure_count));
        end
    end

endmodule

// ==== sources.f ====
+incdir+source
source/icache_pkg.sv
source/icache_write_if.sv
source/icache_sram.sv
source/icache_lookup.sv
source/icache_miss_handler.sv
source/icache_top.sv
verif/icache_assertions.sv
verif/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/icache_pkg.sv
      - source/icache_write_if.sv
      - source/icache_sram.sv
      - source/icache_lookup.sv
      - source/icache_miss_handler.sv
      - source/icache_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/icache_assertions.sv
      - verif/icache_tb.sv
